// ==== design/irq_settings.svh ====
// Build-wide sizes and reset constants for the interrupt vector unit
`ifndef IRQ_SETTINGS_SVH
`define IRQ_SETTINGS_SVH

// Number of interrupt request lines
`define IRQ_LINES 8

// Handler address width, also the Wishbone data width
`define IRQ_VEC_W 32

// Vector table contents after reset
// Entry n holds base + stride * n
`define IRQ_VEC_BASE 32'h5000_0000
`define IRQ_VEC_STRIDE 16

// Wishbone byte address width
// Bits 1:0 select a byte lane and are not decoded
`define WB_ADR_W 6

`endif

// ==== design/irq_types_pkg.sv ====
// Interrupt-side types: line vectors, line index and handler address
`include "irq_settings.svh"

package irq_types_pkg;

    // One bit per request line, bit n is line n
    typedef logic [`IRQ_LINES-1:0] irq_lines_t;

    // Line number as produced by the priority encoder
    typedef logic [$clog2(`IRQ_LINES)-1:0] irq_index_t;

    // Handler address stored in the vector table
    typedef logic [`IRQ_VEC_W-1:0] irq_vector_t;

    // Byte lanes in one handler address word
    localparam int unsigned VEC_BYTES = `IRQ_VEC_W / 8;

endpackage

// ==== design/wb_regs_pkg.sv ====
// Wishbone register map: word address type and register enum
`include "irq_settings.svh"

package wb_regs_pkg;

    // Word address, byte address bits above the lane select
    typedef logic [`WB_ADR_W-3:0] wb_word_adr_t;

    // Register map by word address
    // Words 0..7 are vector table entries, word 8 is the mask
    // Everything above is unmapped and reads as zero
    typedef enum wb_word_adr_t {
        REG_VEC0 = 0,
        REG_VEC1 = 1,
        REG_VEC2 = 2,
        REG_VEC3 = 3,
        REG_VEC4 = 4,
        REG_VEC5 = 5,
        REG_VEC6 = 6,
        REG_VEC7 = 7,
        REG_MASK = 8
    } reg_map_e;

endpackage

// ==== design/irq_edge_capture.sv ====
// Interrupt line sampling, rising edge detection and masking
`timescale 1ns/100ps

module irq_edge_capture (
    input  logic                      clk_buf,
    input  logic                      rst_buf,
    input  irq_types_pkg::irq_lines_t int_in,
    input  irq_types_pkg::irq_lines_t mask_bits,
    output irq_types_pkg::irq_lines_t edge_hits
);

    // Previous raw sample of the request lines
    irq_types_pkg::irq_lines_t int_prev;

    // Rising edge on lines that are not masked
    irq_types_pkg::irq_lines_t rise_now;

    // Mask bit set means the line is blocked
    assign rise_now = int_in & ~int_prev & ~mask_bits;

    always_ff @(posedge clk_buf or posedge rst_buf) begin
        if (rst_buf) begin
            int_prev  <= '0;
            edge_hits <= '0;
        end else begin
            // Raw sample, so a line held high while masked
            // shows no edge once it is unmasked
            int_prev  <= int_in;
            // Stage 0 result for the priority encoder
            edge_hits <= rise_now;
        end
    end

endmodule

// ==== design/irq_prio_encode.sv ====
// Priority encoder with two register stages for line index and valid
`timescale 1ns/100ps
`include "irq_settings.svh"

module irq_prio_encode (
    input  logic                      clk_buf,
    input  logic                      rst_buf,
    input  irq_types_pkg::irq_lines_t edge_hits,
    output irq_types_pkg::irq_index_t sel_index,
    output logic                      sel_valid
);

    // Combinational encoder result
    irq_types_pkg::irq_index_t enc_index;
    logic                      enc_valid;

    // First register stage
    irq_types_pkg::irq_index_t index_s1;
    logic                      valid_s1;

    // Highest set bit wins
    // Loop runs upward so the last hit overrides lower ones
    always_comb begin
        enc_index = '0;
        for (int i = 0; i < `IRQ_LINES; i++) begin
            if (edge_hits[i]) begin
                enc_index = irq_types_pkg::irq_index_t'(i);
            end
        end
    end

    // Any edge at all gives a valid request
    assign enc_valid = |edge_hits;

    // Stage 1, encoder output registered
    always_ff @(posedge clk_buf or posedge rst_buf) begin
        if (rst_buf) begin
            index_s1 <= '0;
            valid_s1 <= 1'b0;
        end else begin
            index_s1 <= enc_index;
            valid_s1 <= enc_valid;
        end
    end

    // Stage 2, retimed copy feeding the table lookup
    always_ff @(posedge clk_buf or posedge rst_buf) begin
        if (rst_buf) begin
            sel_index <= '0;
            sel_valid <= 1'b0;
        end else begin
            sel_index <= index_s1;
            sel_valid <= valid_s1;
        end
    end

endmodule

// ==== design/irq_regs.sv ====
// Wishbone classic slave with mask register, vector table and lookup stage
`timescale 1ns/100ps
`include "irq_settings.svh"

module irq_regs (
    input  logic                       clk_buf,
    input  logic                       rst_buf,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [`WB_ADR_W-1:0]       wb_adr,
    input  irq_types_pkg::irq_vector_t wb_dat_w,
    input  logic [3:0]                 wb_sel,
    output irq_types_pkg::irq_vector_t wb_dat_r,
    output logic                       wb_ack,
    input  irq_types_pkg::irq_index_t  sel_index,
    input  logic                       sel_valid,
    output irq_types_pkg::irq_lines_t  mask_bits,
    output irq_types_pkg::irq_vector_t vector,
    output logic                       valid
);

    // Address decode
    wb_regs_pkg::wb_word_adr_t word_adr;
    wb_regs_pkg::reg_map_e     reg_sel;
    irq_types_pkg::irq_index_t tbl_idx;

    // Bus cycle control
    logic bus_start;
    logic wr_vec;
    logic wr_mask;

    // Read mux and byte merge
    irq_types_pkg::irq_vector_t rd_data;
    irq_types_pkg::irq_vector_t wr_merged;

    // Handler address table, one entry per line
    irq_types_pkg::irq_vector_t vec_table [`IRQ_LINES];

    assign word_adr = wb_adr[`WB_ADR_W-1:2];
    assign reg_sel  = wb_regs_pkg::reg_map_e'(word_adr);
    // Low word address bits pick the table entry
    assign tbl_idx  = irq_types_pkg::irq_index_t'(word_adr);

    // New request seen while no ack is out
    // A held stb therefore gets an ack every second cycle
    assign bus_start = wb_cyc && wb_stb && !wb_ack;

    // Register select, write strobes and read data
    always_comb begin
        wr_vec  = 1'b0;
        wr_mask = 1'b0;
        rd_data = '0;
        case (reg_sel)
            wb_regs_pkg::REG_VEC0, wb_regs_pkg::REG_VEC1,
            wb_regs_pkg::REG_VEC2, wb_regs_pkg::REG_VEC3,
            wb_regs_pkg::REG_VEC4, wb_regs_pkg::REG_VEC5,
            wb_regs_pkg::REG_VEC6, wb_regs_pkg::REG_VEC7: begin
                wr_vec  = bus_start && wb_we;
                rd_data = vec_table[tbl_idx];
            end
            wb_regs_pkg::REG_MASK: begin
                wr_mask = bus_start && wb_we;
                rd_data = {{(`IRQ_VEC_W-`IRQ_LINES){1'b0}}, mask_bits};
            end
            // Unmapped words read zero and drop writes
            default: begin
                rd_data = '0;
            end
        endcase
    end

    // Byte lane merge of write data into the addressed entry
    always_comb begin
        wr_merged = vec_table[tbl_idx];
        for (int b = 0; b < irq_types_pkg::VEC_BYTES; b++) begin
            if (wb_sel[b]) begin
                wr_merged[b*8 +: 8] = wb_dat_w[b*8 +: 8];
            end
        end
    end

    // Control state, table and lookup stage
    always_ff @(posedge clk_buf or posedge rst_buf) begin
        if (rst_buf) begin
            wb_ack    <= 1'b0;
            mask_bits <= '0;
            vector    <= '0;
            valid     <= 1'b0;
            // Table comes up with the fixed handler layout
            for (int i = 0; i < `IRQ_LINES; i++) begin
                vec_table[i] <= `IRQ_VEC_BASE + `IRQ_VEC_W'(`IRQ_VEC_STRIDE * i);
            end
        end else begin
            // Single cycle ack, write lands on the same edge
            wb_ack <= bus_start;
            if (wr_vec) begin
                vec_table[tbl_idx] <= wr_merged;
            end
            // Only lane 0 carries mask bits
            if (wr_mask && wb_sel[0]) begin
                mask_bits <= wb_dat_w[`IRQ_LINES-1:0];
            end
            // Final stage, lookup sees the table before this edge
            vector <= vec_table[sel_index];
            valid  <= sel_valid;
        end
    end

    // Read data is captured with the ack and held after it
    always_ff @(posedge clk_buf) begin
        if (bus_start) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

// ==== design/irq_vector_unit.sv ====
// Top level of the interrupt vector unit joining capture, encoder and registers
`timescale 1ns/100ps
`include "irq_settings.svh"

module irq_vector_unit (
    input  logic                       clk_buf,
    input  logic                       rst_buf,
    input  irq_types_pkg::irq_lines_t  int_in,
    output irq_types_pkg::irq_vector_t vector,
    output logic                       valid,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [`WB_ADR_W-1:0]       wb_adr,
    input  irq_types_pkg::irq_vector_t wb_dat_w,
    input  logic [3:0]                 wb_sel,
    output irq_types_pkg::irq_vector_t wb_dat_r,
    output logic                       wb_ack
);

    // Stage 0 output, masked rising edges
    irq_types_pkg::irq_lines_t edge_hits;

    // Stage 2 output, winning line and its valid
    irq_types_pkg::irq_index_t sel_index;
    logic                      sel_valid;

    // Mask register fed back to the edge detector
    irq_types_pkg::irq_lines_t mask_bits;

    // Sample lines and detect masked rising edges
    irq_edge_capture u_edge_capture (
        .clk_buf   (clk_buf),
        .rst_buf   (rst_buf),
        .int_in    (int_in),
        .mask_bits (mask_bits),
        .edge_hits (edge_hits)
    );

    // Pick the highest line, two register stages
    irq_prio_encode u_prio_encode (
        .clk_buf   (clk_buf),
        .rst_buf   (rst_buf),
        .edge_hits (edge_hits),
        .sel_index (sel_index),
        .sel_valid (sel_valid)
    );

    // Bus registers and the final vector lookup
    irq_regs u_regs (
        .clk_buf   (clk_buf),
        .rst_buf   (rst_buf),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_sel    (wb_sel),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .sel_index (sel_index),
        .sel_valid (sel_valid),
        .mask_bits (mask_bits),
        .vector    (vector),
        .valid     (valid)
    );

endmodule

// ==== dv/irq_asserts.sv ====
// Concurrent assertions on the Wishbone handshake and the vector output, with their bind
`timescale 1ns/100ps

module irq_asserts (
    input logic                       clk_buf,
    input logic                       rst_buf,
    input logic                       wb_cyc,
    input logic                       wb_stb,
    input logic                       wb_ack,
    input logic                       valid,
    input irq_types_pkg::irq_vector_t vector
);

    // Failure tally, read by the testbench report
    int fail_count = 0;

    // Ack is a one cycle pulse
    ack_single_cycle: assert property (@(posedge clk_buf) disable iff (rst_buf)
        wb_ack |=> !wb_ack)
    else begin
        fail_count = fail_count + 1;
        $error("wb_ack stayed high for two cycles");
    end

    // Ack only answers a request seen on the edge before
    ack_after_request: assert property (@(posedge clk_buf) disable iff (rst_buf)
        wb_ack |-> $past(wb_cyc && wb_stb))
    else begin
        fail_count = fail_count + 1;
        $error("wb_ack raised without cyc and stb");
    end

    // A strobed vector carries a known address
    vector_known: assert property (@(posedge clk_buf) disable iff (rst_buf)
        valid |-> !$isunknown(vector))
    else begin
        fail_count = fail_count + 1;
        $error("valid high with unknown vector bits");
    end

endmodule

// Attach to every instance of the top level
bind irq_vector_unit irq_asserts u_asserts (
    .clk_buf (clk_buf),
    .rst_buf (rst_buf),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_ack  (wb_ack),
    .valid   (valid),
    .vector  (vector)
);

// ==== dv/irq_checker.sv ====
// Reference model and scoreboard for vector strobes and Wishbone responses
`timescale 1ns/100ps
`include "irq_settings.svh"

module irq_checker (
    input  logic                       clk_buf,
    input  logic                       rst_buf,
    input  irq_types_pkg::irq_lines_t  int_in,
    input  irq_types_pkg::irq_vector_t vector,
    input  logic                       valid,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [`WB_ADR_W-1:0]       wb_adr,
    input  irq_types_pkg::irq_vector_t wb_dat_w,
    input  logic [3:0]                 wb_sel,
    input  irq_types_pkg::irq_vector_t wb_dat_r,
    input  logic                       wb_ack,
    output int                         vec_errors,
    output int                         bus_errors
);

    // Model of the line sampler and mask
    irq_types_pkg::irq_lines_t  m_prev;
    irq_types_pkg::irq_lines_t  m_hits;
    irq_types_pkg::irq_lines_t  m_mask;
    // Two encoder stages
    irq_types_pkg::irq_index_t  m_idx1;
    irq_types_pkg::irq_index_t  m_idx2;
    logic                       m_val1;
    logic                       m_val2;
    irq_types_pkg::irq_vector_t m_table [`IRQ_LINES];

    // Expected DUT outputs after the latest rising edge
    irq_types_pkg::irq_vector_t exp_vector;
    logic                       exp_valid;
    logic                       exp_ack;
    logic                       exp_read;
    irq_types_pkg::irq_vector_t exp_dat_r;
    logic                       armed = 1'b0;

    int vec_err_cnt = 0;
    int bus_err_cnt = 0;

    assign vec_errors = vec_err_cnt;
    assign bus_errors = bus_err_cnt;

    // Highest line set, searched from the top down
    function automatic irq_types_pkg::irq_index_t top_line(
        input irq_types_pkg::irq_lines_t bits
    );
        for (int i = `IRQ_LINES - 1; i > 0; i--) begin
            if (bits[i]) begin
                return irq_types_pkg::irq_index_t'(i);
            end
        end
        return '0;
    endfunction

    // Register file read as seen from the bus
    function automatic irq_types_pkg::irq_vector_t bus_read(input wb_regs_pkg::wb_word_adr_t word);
        if (word <= wb_regs_pkg::wb_word_adr_t'(wb_regs_pkg::REG_VEC7)) begin
            return m_table[word[2:0]];
        end
        if (word == wb_regs_pkg::wb_word_adr_t'(wb_regs_pkg::REG_MASK)) begin
            return {{(`IRQ_VEC_W - `IRQ_LINES){1'b0}}, m_mask};
        end
        return '0;
    endfunction

    // State update on each edge, inputs are stable here
    always @(posedge clk_buf or posedge rst_buf) begin
        wb_regs_pkg::wb_word_adr_t word;
        if (rst_buf) begin
            armed     = 1'b0;
            m_prev    = '0;
            m_hits    = '0;
            m_mask    = '0;
            m_idx1    = '0;
            m_idx2    = '0;
            m_val1    = 1'b0;
            m_val2    = 1'b0;
            exp_vector = '0;
            exp_valid = 1'b0;
            exp_ack   = 1'b0;
            exp_read  = 1'b0;
            for (int n = 0; n < `IRQ_LINES; n++) begin
                m_table[n] = irq_types_pkg::irq_vector_t'(`IRQ_VEC_BASE + `IRQ_VEC_STRIDE * n);
            end
        end else begin
            armed = 1'b1;
            // Lookup uses the table as it stood before this edge
            exp_vector = m_table[m_idx2];
            exp_valid  = m_val2;
            m_idx2 = m_idx1;
            m_val2 = m_val1;
            m_idx1 = top_line(m_hits);
            m_val1 = |m_hits;
            // Old mask applies, raw sample kept
            m_hits = int_in & ~m_prev & ~m_mask;
            m_prev = int_in;
            word = wb_adr[`WB_ADR_W-1:2];
            if (wb_cyc && wb_stb && !exp_ack) begin
                exp_ack   = 1'b1;
                exp_read  = !wb_we;
                exp_dat_r = bus_read(word);
                if (wb_we && word <= wb_regs_pkg::wb_word_adr_t'(wb_regs_pkg::REG_VEC7)) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wb_sel[b]) begin
                            m_table[word[2:0]][b*8 +: 8] = wb_dat_w[b*8 +: 8];
                        end
                    end
                end
                // Mask lives in byte lane 0
                if (wb_we && wb_sel[0]
                    && word == wb_regs_pkg::wb_word_adr_t'(wb_regs_pkg::REG_MASK)) begin
                    m_mask = wb_dat_w[`IRQ_LINES-1:0];
                end
            end else begin
                exp_ack = 1'b0;
            end
        end
    end

    // Compare in mid cycle, DUT outputs are settled
    always @(negedge clk_buf) begin
        if (armed) begin
            if (valid !== exp_valid || vector !== exp_vector) begin
                vec_err_cnt = vec_err_cnt + 1;
                $display("** Error @ %0t: valid=%b vector=%h, expected valid=%b vector=%h",
                         $time, valid, vector, exp_valid, exp_vector);
            end
            if (wb_ack !== exp_ack) begin
                bus_err_cnt = bus_err_cnt + 1;
                $display("** Error @ %0t: wb_ack=%b, expected %b", $time, wb_ack, exp_ack);
            end else if (exp_ack && exp_read && wb_dat_r !== exp_dat_r) begin
                bus_err_cnt = bus_err_cnt + 1;
                $display("** Error @ %0t: read data %h, expected %h", $time, wb_dat_r, exp_dat_r);
            end
        end
    end

endmodule

// ==== dv/tb_top.sv ====
// Testbench top with clock, reset, random line and Wishbone stimulus, timeout and report
`timescale 1ns/100ps
`include "irq_settings.svh"

module tb_top;

    // Phase length and the overall cycle limit
    localparam int PHASE_CYCLES   = 2000;
    localparam int NUM_PHASES     = 4;
    localparam int TIMEOUT_CYCLES = NUM_PHASES * PHASE_CYCLES + 200;

    // Word address of the mask register
    localparam wb_regs_pkg::wb_word_adr_t MASK_WORD = wb_regs_pkg::REG_MASK;

    logic                       clk_buf;
    logic                       rst_buf;
    irq_types_pkg::irq_lines_t  int_in;
    irq_types_pkg::irq_vector_t vector;
    logic                       valid;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    logic [`WB_ADR_W-1:0]       wb_adr;
    irq_types_pkg::irq_vector_t wb_dat_w;
    logic [3:0]                 wb_sel;
    irq_types_pkg::irq_vector_t wb_dat_r;
    logic                       wb_ack;

    int          vec_errors;
    int          bus_errors;
    int          total_errors;
    int          cycle_count = 0;
    logic [31:0] rng_state;

    irq_vector_unit UUT (
        .clk_buf (clk_buf),
        .rst_buf (rst_buf),
        .int_in  (int_in),
        .vector  (vector),
        .valid   (valid),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_adr  (wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_sel  (wb_sel),
        .wb_dat_r(wb_dat_r),
        .wb_ack  (wb_ack)
    );

    // Scoreboard on the same ports
    irq_checker u_checker (
        .clk_buf   (clk_buf),
        .rst_buf   (rst_buf),
        .int_in    (int_in),
        .vector    (vector),
        .valid     (valid),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_sel    (wb_sel),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .vec_errors(vec_errors),
        .bus_errors(bus_errors)
    );

    // 40 ns period
    initial begin
        clk_buf = 1'b0;
        forever #20 clk_buf = ~clk_buf;
    end

    // Cycle limit guard
    always @(posedge clk_buf) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    // Xorshift step, 13/17/5 shifts
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // One cycle, lines toggle sparsely so some stay high for a while
    task automatic tick();
        logic [31:0] r1;
        logic [31:0] r2;
        @(negedge clk_buf);
        r1 = next_rand();
        r2 = next_rand();
        int_in = int_in ^ irq_types_pkg::irq_lines_t'(r1 & r2);
    endtask

    // Classic cycle, request held until ack is seen
    task automatic wb_cycle(input logic we, input logic [`WB_ADR_W-1:0] adr,
                            input logic [31:0] dat, input logic [3:0] sel);
        tick();
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        wb_sel   = sel;
        do begin
            tick();
        end while (!wb_ack);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic run_phase(input int kind);
        int          start;
        logic [31:0] r;
        logic [31:0] d;
        start = cycle_count;
        while (cycle_count - start < PHASE_CYCLES) begin
            r = next_rand();
            d = next_rand();
            case (kind)
                // Sparse random masks, random lanes and byte offsets
                1: begin
                    if (r[2:0] == 3'd0) begin
                        wb_cycle(1'b1, {MASK_WORD, r[9:8]}, d & next_rand(), r[13:10]);
                    end else if (r[2:0] == 3'd1) begin
                        wb_cycle(1'b0, {MASK_WORD, r[9:8]}, d, 4'hf);
                    end else begin
                        tick();
                    end
                end
                // Byte-enabled table writes and readback
                2: begin
                    if (r[1:0] == 2'd0) begin
                        wb_cycle(1'b1, {1'b0, r[4:2], r[9:8]}, d, r[13:10]);
                    end else if (r[1:0] == 2'd1) begin
                        wb_cycle(1'b0, {1'b0, r[4:2], r[9:8]}, d, 4'hf);
                    end else begin
                        tick();
                    end
                end
                // Reads over the whole space, stray writes too
                3: begin
                    if (r[0]) begin
                        wb_cycle(r[3:1] == 3'd0, r[15:10], d, r[19:16]);
                    end else begin
                        tick();
                    end
                end
                // Lines only
                default: tick();
            endcase
        end
    endtask

    initial begin
        rst_buf   = 1'b1;
        int_in    = '0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        wb_sel    = '0;
        rng_state = 32'h280a;
        repeat (10) @(negedge clk_buf);
        rst_buf = 1'b0;
        run_phase(0);
        run_phase(1);
        // Open all lines so table rewrites show up
        wb_cycle(1'b1, {MASK_WORD, 2'b00}, 32'h0, 4'hf);
        run_phase(2);
        run_phase(3);
        // Drain the pipeline
        repeat (8) tick();
        // Step off the falling edge so the last mid-cycle compare has landed
        #1;
        total_errors = vec_errors + bus_errors + UUT.u_asserts.fail_count;
        $display("Errors: vector %0d, bus %0d, assertion %0d",
                 vec_errors, bus_errors, UUT.u_asserts.fail_count);
        if (total_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+design
design/irq_types_pkg.sv
design/wb_regs_pkg.sv
design/irq_edge_capture.sv
design/irq_prio_encode.sv
design/irq_regs.sv
design/irq_vector_unit.sv
dv/irq_asserts.sv
dv/irq_checker.sv
dv/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the interrupt vector unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_top -f tb.f -Mdir obj_dir -o tb_top_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past assertion errors so the testbench prints its report
./obj_dir/tb_top_sim +verilator+error+limit+1000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    echo "Simulation reported failures, see $LOG"
    exit 1
fi

echo "Simulation passed"
exit 0
